// File: sim.f
+incdir+.
hdl/corePkg.sv
hdl/instQueue.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/executeStage.sv
hdl/datapathTop.sv
tb/datapathTb.sv

// File: Bender.yml
package:
  name: datapath

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hdl/corePkg.sv
      - hdl/instQueue.sv
      - hdl/decoder.sv
      - hdl/regFile.sv
      - hdl/alu.sv
      - hdl/executeStage.sv
      - hdl/datapathTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb/datapathTb.sv

// File: tb/datapathTb.sv
`include "core_cfg.svh"

module datapathTb;
	import corePkg::*;

	// one expected instruction outcome, popped at its creditReturn
	typedef struct packed {
		logic hasRes;
		regIndex resReg;
		dataWord resData;
		logic hasStore;
		memIndex storeAddr;
		dataWord storeData;
	} expectEntry;

	logic clk;
	logic reset;
	logic instValid;
	instWord inst;
	logic creditReturn;
	logic resValid;
	regIndex resReg;
	dataWord resData;
	logic storeValid;
	memIndex storeAddr;
	dataWord storeData;

	// sender side
	int credits;
	int creditPulses;
	logic [31:0] lfsrState;

	// reference state
	dataWord modelRegs [0:`REG_COUNT-1];
	dataWord modelMem [0:`MEM_DEPTH-1];
	logic modelCarry;
	expectEntry expQ [$];

	// checker side
	expectEntry pendingEntry;
	logic pending;
	dataWord lastRes [0:`REG_COUNT-1];
	memIndex lastStoreAddr;
	dataWord lastStoreData;
	int valueErrors;
	int otherErrors;

	datapathTop dut0 (
		.clk(clk),
		.reset(reset),
		.instValid(instValid),
		.inst(inst),
		.creditReturn(creditReturn),
		.resValid(resValid),
		.resReg(resReg),
		.resData(resData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////
	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			valueErrors++;
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic abortRun(input string reason);
		otherErrors++;
		$display("%s", reason);
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		$display("tests failed");
		$finish;
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic instWord encImm(input logic [3:0] major, input regIndex dest,
			input logic [7:0] value);
		return {2'b00, major, dest, value};
	endfunction

	function automatic instWord encReg(input logic [3:0] major, input logic [3:0] minor,
			input regIndex dest, input regIndex src);
		return {2'b00, major, dest, minor, src};
	endfunction

	// pick among r-type, shift and immediate compare forms
	function automatic instWord randomAluInst(input int sel, input regIndex dest,
			input regIndex src, input logic [7:0] value);
		case (sel % 19)
			0: return encReg(RTYPE, ADD, dest, src);
			1: return encReg(RTYPE, ADDU, dest, src);
			2: return encReg(RTYPE, ADDC, dest, src);
			3: return encReg(RTYPE, ADDCU, dest, src);
			4: return encReg(RTYPE, SUB, dest, src);
			5: return encReg(RTYPE, CMP, dest, src);
			6: return encReg(RTYPE, AND, dest, src);
			7: return encReg(RTYPE, OR, dest, src);
			8: return encReg(RTYPE, XOR, dest, src);
			9: return encReg(RTYPE, NOT, dest, src);
			10: return encReg(RTYPE, MOV, dest, src);
			11: return encReg(SHIFT, LSH, dest, src);
			12: return encReg(SHIFT, LSHI, dest, src);
			13: return encReg(SHIFT, RSH, dest, src);
			14: return encReg(SHIFT, RSHI, dest, src);
			15: return encReg(SHIFT, ALSH, dest, src);
			16: return encReg(SHIFT, ARSH, dest, src);
			17: return encImm(CMPI, dest, value);
			default: return encImm(CMPUI, dest, value);
		endcase
	endfunction

	////////////////////
	// reference model
	////////////////////
	function automatic dataWord modelAdd(input dataWord x, input dataWord y, input logic cin);
		logic [16:0] wide;
		wide = {1'b0, x} + {1'b0, y} + {16'b0, cin};
		modelCarry = wide[16];
		return wide[15:0];
	endfunction

	function automatic void modelInst(input instWord w);
		regIndex dest;
		regIndex src;
		dataWord a;
		dataWord b;
		dataWord immS;
		dataWord immZ;
		expectEntry e;
		dest = w[11:8];
		src = w[3:0];
		a = modelRegs[dest];
		b = modelRegs[src];
		immS = {{8{w[7]}}, w[7:0]};
		immZ = {8'h00, w[7:0]};
		// anything not decoded rewrites dest with itself
		e = '0;
		e.hasRes = 1'b1;
		e.resReg = dest;
		e.resData = a;
		if (w[17:16] == 2'b11) begin
			e.resData = w[15:0];
		end else if (w[17:16] == 2'b00) begin
			case (w[15:12])
				RTYPE: begin
					case (w[7:4])
						ADD, ADDU: e.resData = modelAdd(a, b, 1'b0);
						ADDC, ADDCU: e.resData = modelAdd(a, b, modelCarry);
						SUB: e.resData = a - b;
						CMP: e.hasRes = 1'b0;
						AND: e.resData = a & b;
						OR: e.resData = a | b;
						XOR: e.resData = a ^ b;
						NOT: e.resData = ~b;
						MOV: e.resData = b;
						default: e.resData = a;
					endcase
				end
				ADDI: e.resData = modelAdd(a, immS, 1'b0);
				ADDUI: e.resData = modelAdd(a, immZ, 1'b0);
				ADDCI: e.resData = modelAdd(a, immS, modelCarry);
				ADDCUI: e.resData = modelAdd(a, immZ, modelCarry);
				SUBI: e.resData = a - immS;
				CMPI, CMPUI: e.hasRes = 1'b0;
				MOVI: e.resData = immZ;
				LUI: e.resData = {w[7:0], 8'h00};
				SHIFT: begin
					case (w[7:4])
						LSH, ALSH: e.resData = a << b[3:0];
						LSHI: e.resData = a << src;
						RSH: e.resData = a >> b[3:0];
						RSHI: e.resData = a >> src;
						// sign bits fill from the top
						ARSH: e.resData = (a >> b[3:0]) | (a[15] ? ~(16'hffff >> b[3:0]) : 16'h0000);
						default: e.resData = a;
					endcase
				end
				MEM: begin
					case (w[7:4])
						LOAD: e.resData = modelMem[src];
						STOR: begin
							e.hasStore = 1'b1;
							e.storeAddr = src;
							e.storeData = a;
							modelMem[src] = a;
						end
						default: e.resData = a;
					endcase
				end
				default: e.resData = a;
			endcase
		end
		if (e.hasRes) begin
			modelRegs[dest] = e.resData;
		end
		expQ.push_back(e);
	endfunction

	////////////////////
	// sender
	////////////////////
	task automatic collectCredit();
		if (creditReturn === 1'b1) begin
			credits++;
			creditPulses++;
			if (credits > `QUEUE_DEPTH) begin
				otherErrors++;
				$display("more credits came back than were spent, at time %0t", $time);
			end
		end
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			collectCredit();
			instValid = 1'b0;
		end
	endtask

	// waits for a credit, then drives one word for one cycle
	task automatic sendInst(input instWord word);
		int waited;
		waited = 0;
		@(negedge clk);
		collectCredit();
		while (credits == 0) begin
			instValid = 1'b0;
			if (waited >= 50) begin
				abortRun("no credit came back within 50 cycles");
			end
			waited++;
			@(negedge clk);
			collectCredit();
		end
		instValid = 1'b1;
		inst = word;
		credits--;
		modelInst(word);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (credits != `QUEUE_DEPTH || expQ.size() != 0 || pending) begin
			if (waited >= 100) begin
				abortRun("the pipeline did not drain within 100 cycles");
			end
			waited++;
			idleCycles(1);
		end
		idleCycles(2);
	endtask

	// r15 is scratch
	task automatic loadReg16(input regIndex dest, input dataWord value);
		sendInst(encImm(LUI, dest, value[15:8]));
		sendInst(encImm(MOVI, 4'd15, value[7:0]));
		sendInst(encReg(RTYPE, OR, dest, 4'd15));
	endtask

	// 32 bit add split over r4:r5 and r6:r7
	task automatic carryChain(input logic [31:0] x, input logic [31:0] y);
		logic [31:0] sum;
		sum = x + y;
		loadReg16(4'd5, x[15:0]);
		loadReg16(4'd4, x[31:16]);
		loadReg16(4'd7, y[15:0]);
		loadReg16(4'd6, y[31:16]);
		sendInst(encReg(RTYPE, ADDU, 4'd5, 4'd7));
		sendInst(encReg(RTYPE, ADDCU, 4'd4, 4'd6));
		drain();
		checkValue("carry sum low", lastRes[5], sum[15:0]);
		checkValue("carry sum high", lastRes[4], sum[31:16]);
	endtask

	task automatic memoryRoundTrip(input memIndex addr, input dataWord value);
		loadReg16(4'd8, value);
		sendInst(encReg(MEM, STOR, 4'd8, addr));
		sendInst(encReg(MEM, LOAD, 4'd9, addr));
		drain();
		checkValue("storeAddr seen", lastStoreAddr, addr);
		checkValue("storeData seen", lastStoreData, value);
		checkValue("load result", lastRes[9], value);
	endtask

	////////////////////
	// checker
	////////////////////
	// a report must follow its creditReturn by exactly one cycle
	initial begin
		pending = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset) begin
				if (pending) begin
					checkValue("resValid", resValid, pendingEntry.hasRes);
					checkValue("storeValid", storeValid, pendingEntry.hasStore);
					if (pendingEntry.hasRes && resValid === 1'b1) begin
						checkValue("resReg", resReg, pendingEntry.resReg);
						checkValue("resData", resData, pendingEntry.resData);
						lastRes[resReg] = resData;
					end
					if (pendingEntry.hasStore && storeValid === 1'b1) begin
						checkValue("storeAddr", storeAddr, pendingEntry.storeAddr);
						checkValue("storeData", storeData, pendingEntry.storeData);
						lastStoreAddr = storeAddr;
						lastStoreData = storeData;
					end
				end else begin
					checkValue("resValid", resValid, 1'b0);
					checkValue("storeValid", storeValid, 1'b0);
				end
				pending = 1'b0;
				// one pop per credit, in send order
				if (creditReturn === 1'b1) begin
					if (expQ.size() == 0) begin
						otherErrors++;
						$display("a credit came back with no instruction outstanding, at %0t", $time);
					end else begin
						pendingEntry = expQ.pop_front();
						pending = 1'b1;
					end
				end
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////
	initial begin
		instWord word;
		reset = 1'b1;
		instValid = 1'b0;
		inst = '0;
		lfsrState = 32'hd5d5_8374;
		credits = 0;
		creditPulses = 0;
		valueErrors = 0;
		otherErrors = 0;
		modelCarry = 1'b0;
		lastStoreAddr = '0;
		lastStoreData = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
			lastRes[i] = '0;
		end
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		credits = `QUEUE_DEPTH;

		// reset state, then a full burst of credits
		idleCycles(1);
		checkValue("creditReturn", creditReturn, 1'b0);
		checkValue("resValid", resValid, 1'b0);
		checkValue("storeValid", storeValid, 1'b0);
		idleCycles(2);
		for (int i = 0; i < `QUEUE_DEPTH; i++) begin
			sendInst(encImm(MOVI, i[3:0], 8'h10 + i[7:0]));
		end
		drain();
		checkValue("creditPulses", creditPulses, `QUEUE_DEPTH);

		// immediate extension
		sendInst(encImm(MOVI, 4'd1, 8'ha5));
		sendInst(encImm(ADDI, 4'd1, 8'h80));
		sendInst(encImm(LUI, 4'd2, 8'h7e));
		sendInst(encImm(ADDUI, 4'd2, 8'h80));
		sendInst(encImm(MOVI, 4'd3, 8'hf0));
		// long form lands in bits 11:8 of its own value
		sendInst({2'b11, 16'hbeef});
		drain();
		checkValue("r1 after addi", lastRes[1], 16'h0025);
		checkValue("r2 after addui", lastRes[2], 16'h7e80);
		checkValue("r3 after movi", lastRes[3], 16'h00f0);
		checkValue("r14 long form", lastRes[14], 16'hbeef);

		// random register ops on seeded registers
		for (int i = 0; i < 15; i++) begin
			loadReg16(i[3:0], randBits(16));
		end
		sendInst(encImm(MOVI, 4'd15, randBits(8)));
		for (int i = 0; i < 60; i++) begin
			sendInst(randomAluInst(randBits(5), randBits(4), randBits(4), randBits(8)));
		end
		drain();

		carryChain(32'h1234_f0f0, 32'h0001_2345);
		carryChain(32'hffff_ffff, 32'h0000_0001);
		carryChain(32'h8000_ffff, 32'h7fff_0001);

		memoryRoundTrip(4'd3, 16'h5a3c);
		memoryRoundTrip(4'd9, 16'hc001);
		memoryRoundTrip(4'd15, 16'h8421);

		// long stream with idle gaps, mostly standard prefix
		for (int i = 0; i < 400; i++) begin
			word = randBits(18);
			if (randBits(2) != 2'b11) begin
				word[17:16] = 2'b00;
			end
			sendInst(word);
			if (randBits(2) == 0) begin
				idleCycles(randBits(2) + 1);
			end
		end
		drain();

		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: hdl/datapathTop.sv
module datapathTop (
	input  logic clk,
	input  logic reset,
	input  logic instValid,
	input  corePkg::instWord inst,
	output logic creditReturn,
	output logic resValid,
	output corePkg::regIndex resReg,
	output corePkg::dataWord resData,
	output logic storeValid,
	output corePkg::memIndex storeAddr,
	output corePkg::dataWord storeData
);
	import corePkg::*;

	// queue head
	logic headValid;
	instWord headInst;

	// decoded fields
	opCode op;
	dataWord imm;
	logic selectImm;
	logic selectResult;
	logic memWrite;
	memIndex memAddr;
	regIndex readRegA;
	regIndex readRegB;
	regIndex loadReg;

	////////////////////
	// queue
	////////////////////
	instQueue queue0 (
		.clk(clk),
		.reset(reset),
		.instValid(instValid),
		.inst(inst),
		.headValid(headValid),
		.headInst(headInst),
		.creditReturn(creditReturn)
	);

	// decode straight off the head entry
	decoder decoder0 (
		.inst(headInst),
		.op(op),
		.imm(imm),
		.selectImm(selectImm),
		.selectResult(selectResult),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.loadReg(loadReg)
	);

	////////////////////
	// execute
	////////////////////
	executeStage execute0 (
		.clk(clk),
		.reset(reset),
		.op(op),
		.imm(imm),
		.selectImm(selectImm),
		.selectResult(selectResult),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.loadReg(loadReg),
		.headValid(headValid),
		.resValid(resValid),
		.resReg(resReg),
		.resData(resData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

endmodule

// File: hdl/executeStage.sv
`include "core_cfg.svh"

module executeStage (
	input  logic clk,
	input  logic reset,
	input  corePkg::opCode op,
	input  corePkg::dataWord imm,
	input  logic selectImm,
	input  logic selectResult,
	input  logic memWrite,
	input  corePkg::memIndex memAddr,
	input  corePkg::regIndex readRegA,
	input  corePkg::regIndex readRegB,
	input  corePkg::regIndex loadReg,
	input  logic headValid,
	output logic resValid,
	output corePkg::regIndex resReg,
	output corePkg::dataWord resData,
	output logic storeValid,
	output corePkg::memIndex storeAddr,
	output corePkg::dataWord storeData
);
	import corePkg::*;

	////////////////////
	// decode register
	////////////////////
	logic exValid;
	opCode exOp;
	dataWord exImm;
	logic exSelectImm;
	logic exSelectResult;
	logic exMemWrite;
	memIndex exMemAddr;
	regIndex exReadRegA;
	regIndex exReadRegB;
	regIndex exLoadReg;

	// operands and results
	dataWord regAData;
	dataWord regBData;
	dataWord operandB;
	dataWord aluResult;
	logic aluCarryOut;
	logic carryFlag;
	logic isCompare;

	dataWord dataMem [0:`MEM_DEPTH-1];

	// latched at the popping edge
	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
		end else begin
			exValid <= headValid;
		end
	end

	always_ff @(posedge clk) begin
		if (headValid) begin
			exOp <= op;
			exImm <= imm;
			exSelectImm <= selectImm;
			exSelectResult <= selectResult;
			exMemWrite <= memWrite;
			exMemAddr <= memAddr;
			exReadRegA <= readRegA;
			exReadRegB <= readRegB;
			exLoadReg <= loadReg;
		end
	end

	////////////////////
	// operand select and alu
	////////////////////
	regFile regFile0 (
		.clk(clk),
		.reset(reset),
		.readRegA(exReadRegA),
		.readRegB(exReadRegB),
		.regAData(regAData),
		.regBData(regBData),
		.writeEnable(resValid),
		.writeReg(exLoadReg),
		.writeData(resData)
	);

	assign operandB = exSelectImm ? exImm : regBData;

	alu alu0 (
		.op(exOp),
		.operandA(regAData),
		.operandB(operandB),
		.carryIn(carryFlag),
		.result(aluResult),
		.carryOut(aluCarryOut)
	);

	// compares keep no flags here
	// so they write nothing
	assign isCompare = (exOp == {RTYPE, CMP}) || (exOp[7:4] == CMPI) || (exOp[7:4] == CMPUI);

	////////////////////
	// reports
	////////////////////
	// describe the write that lands at the closing edge
	assign resValid = exValid && !isCompare;
	assign resReg = exLoadReg;
	// load takes the memory word over the alu
	assign resData = exSelectResult ? dataMem[exMemAddr] : aluResult;

	// store data comes from the dest register on port A
	assign storeValid = exValid && exMemWrite;
	assign storeAddr = exMemAddr;
	assign storeData = regAData;

	// carry only moves on add forms, alu passes it through otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			carryFlag <= 1'b0;
		end else if (exValid) begin
			carryFlag <= aluCarryOut;
		end
	end

	// data memory
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				dataMem[i] <= '0;
			end
		end else if (storeValid) begin
			dataMem[exMemAddr] <= storeData;
		end
	end

endmodule

// File: hdl/alu.sv
module alu (
	input  corePkg::opCode op,
	input  corePkg::dataWord operandA,
	input  corePkg::dataWord operandB,
	input  logic carryIn,
	output corePkg::dataWord result,
	output logic carryOut
);
	import corePkg::*;

	// 17 bit sums, top bit is the carry
	logic [16:0] addSum;
	logic [16:0] addCarrySum;
	logic [3:0] shiftAmount;

	assign addSum = {1'b0, operandA} + {1'b0, operandB};
	assign addCarrySum = addSum + {16'b0, carryIn};
	// only the low nibble of B counts for shifts
	assign shiftAmount = operandB[3:0];

	always_comb begin
		// non-add ops pass the carry straight through
		result = '0;
		carryOut = carryIn;
		case (op[7:4])
			RTYPE: begin
				case (op[3:0])
					ADD, ADDU: {carryOut, result} = addSum;
					ADDC, ADDCU: {carryOut, result} = addCarrySum;
					SUB: result = operandA - operandB;
					AND: result = operandA & operandB;
					OR: result = operandA | operandB;
					XOR: result = operandA ^ operandB;
					NOT: result = ~operandB;
					MOV: result = operandA;
					// compare leaves nothing behind
					default: result = '0;
				endcase
			end
			SHIFT: begin
				case (op[3:0])
					// arithmetic left is the same as logical left
					LSH, LSHI, ALSH: result = operandA << shiftAmount;
					RSH, RSHI: result = operandA >> shiftAmount;
					ARSH: result = $signed(operandA) >>> shiftAmount;
					default: result = '0;
				endcase
			end
			ADDI, ADDUI: {carryOut, result} = addSum;
			ADDCI, ADDCUI: {carryOut, result} = addCarrySum;
			SUBI: result = operandA - operandB;
			// imm already shaped by the decoder
			MOVI, LUI: result = operandB;
			default: result = '0;
		endcase
	end

endmodule

// File: hdl/regFile.sv
`include "core_cfg.svh"

module regFile (
	input  logic clk,
	input  logic reset,
	input  corePkg::regIndex readRegA,
	input  corePkg::regIndex readRegB,
	output corePkg::dataWord regAData,
	output corePkg::dataWord regBData,
	input  logic writeEnable,
	input  corePkg::regIndex writeReg,
	input  corePkg::dataWord writeData
);
	import corePkg::*;

	dataWord regs [0:`REG_COUNT-1];

	// async reads
	// same cycle write is not bypassed
	assign regAData = regs[readRegA];
	assign regBData = regs[readRegB];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeReg] <= writeData;
		end
	end

endmodule

// File: hdl/decoder.sv
module decoder (
	input  corePkg::instWord inst,
	output corePkg::opCode op,
	output corePkg::dataWord imm,
	output logic selectImm,
	output logic selectResult,
	output logic memWrite,
	output corePkg::memIndex memAddr,
	output corePkg::regIndex readRegA,
	output corePkg::regIndex readRegB,
	output corePkg::regIndex loadReg
);
	import corePkg::*;

	// instruction fields
	// [17:16] prefix, [15:12] major, [11:8] dest
	// [7:4] minor or imm high, [3:0] src or imm low

	always_comb begin
		////////////////////
		// defaults are the no-op
		////////////////////
		// OR of the destination with itself
		op = {RTYPE, OR};
		imm = '0;
		selectImm = 1'b0;
		selectResult = 1'b0;
		memWrite = 1'b0;
		memAddr = 4'b1010;
		readRegA = inst[11:8];
		readRegB = inst[11:8];
		loadReg = inst[11:8];

		case (inst[17:16])
			2'b00: begin
				case (inst[15:12])
					RTYPE: begin
						case (inst[7:4])
							ADD, ADDU, ADDC, ADDCU, SUB, CMP, AND, OR, XOR, NOT: begin
								op = {RTYPE, inst[7:4]};
								readRegB = inst[3:0];
							end
							// move reads its source on port A
							MOV: begin
								op = {RTYPE, MOV};
								readRegA = inst[3:0];
								readRegB = inst[3:0];
							end
							default: begin
							end
						endcase
					end
					// signed byte immediates
					ADDI, ADDCI, SUBI, CMPI: begin
						op = {inst[15:12], 4'b0000};
						readRegB = inst[3:0];
						selectImm = 1'b1;
						imm = {{8{inst[7]}}, inst[7:0]};
					end
					// unsigned byte immediates
					ADDUI, ADDCUI, CMPUI, MOVI: begin
						op = {inst[15:12], 4'b0000};
						readRegB = inst[3:0];
						selectImm = 1'b1;
						imm = {8'b0000_0000, inst[7:0]};
					end
					// byte lands in the upper half
					LUI: begin
						op = {LUI, 4'b0000};
						readRegB = inst[3:0];
						selectImm = 1'b1;
						imm = {inst[7:0], 8'b0000_0000};
					end
					SHIFT: begin
						case (inst[7:4])
							LSH, RSH, ALSH, ARSH: begin
								op = {SHIFT, inst[7:4]};
								readRegB = inst[3:0];
							end
							// shift amount from the low nibble
							LSHI, RSHI: begin
								op = {SHIFT, inst[7:4]};
								readRegB = inst[3:0];
								selectImm = 1'b1;
								imm = {12'b0000_0000_0000, inst[3:0]};
							end
							default: begin
							end
						endcase
					end
					MEM: begin
						case (inst[7:4])
							// dest gets mem[inst[3:0]]
							LOAD: begin
								memAddr = inst[3:0];
								readRegA = inst[3:0];
								readRegB = inst[3:0];
								selectResult = 1'b1;
							end
							// mem[inst[3:0]] gets dest register
							STOR: begin
								memAddr = inst[3:0];
								memWrite = 1'b1;
							end
							// no pc here, jumps fall through as no-ops
							JCOND: begin
								memAddr = inst[11:8];
							end
							default: begin
							end
						endcase
					end
					default: begin
					end
				endcase
			end
			// long form with a full 16 bit immediate
			2'b11: begin
				op = {LUI, inst[7:4]};
				selectImm = 1'b1;
				imm = inst[15:0];
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hdl/instQueue.sv
`include "core_cfg.svh"

module instQueue (
	input  logic clk,
	input  logic reset,
	input  logic instValid,
	input  corePkg::instWord inst,
	output logic headValid,
	output corePkg::instWord headInst,
	output logic creditReturn
);
	import corePkg::*;

	localparam int ptrWidth = $clog2(`QUEUE_DEPTH);

	// circular buffer storage
	instWord entries [0:`QUEUE_DEPTH-1];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	// one extra bit so a full queue is distinct from empty
	logic [ptrWidth:0] count;
	logic pop;

	// execute never stalls
	// so any held entry leaves at the next edge
	assign pop = (count != '0);

	assign headValid = pop;
	assign headInst = entries[rdPtr];
	// one credit back per pop
	assign creditReturn = pop;

	////////////////////
	// pointers and occupancy
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			// pointers wrap on their own with a power of two depth
			if (instValid) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({instValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// sender only writes while holding a credit
	// so this never lands on a full queue
	always_ff @(posedge clk) begin
		if (instValid) begin
			entries[wrPtr] <= inst;
		end
	end

endmodule

// File: hdl/corePkg.sv
package corePkg;

	////////////////////
	// widths
	////////////////////
	typedef logic [17:0] instWord;
	typedef logic [15:0] dataWord;
	typedef logic [3:0] regIndex;
	typedef logic [3:0] memIndex;
	// major nibble in [7:4], minor nibble in [3:0]
	typedef logic [7:0] opCode;

	////////////////////
	// major nibbles
	////////////////////
	localparam logic [3:0] RTYPE = 4'b0000;
	localparam logic [3:0] SHIFT = 4'b1000;
	localparam logic [3:0] MEM = 4'b0100;

	// immediate forms, major nibble only
	localparam logic [3:0] ADDI = 4'b0101;
	localparam logic [3:0] ADDUI = 4'b0110;
	localparam logic [3:0] ADDCI = 4'b0111;
	localparam logic [3:0] ADDCUI = 4'b1010;
	localparam logic [3:0] SUBI = 4'b1001;
	localparam logic [3:0] CMPI = 4'b1011;
	localparam logic [3:0] CMPUI = 4'b1110;
	localparam logic [3:0] MOVI = 4'b1101;
	localparam logic [3:0] LUI = 4'b1111;

	////////////////////
	// minor nibbles
	////////////////////
	// r-type
	localparam logic [3:0] ADD = 4'b0101;
	localparam logic [3:0] ADDU = 4'b0110;
	localparam logic [3:0] ADDC = 4'b0111;
	localparam logic [3:0] ADDCU = 4'b0100;
	localparam logic [3:0] SUB = 4'b1001;
	localparam logic [3:0] CMP = 4'b1011;
	localparam logic [3:0] AND = 4'b0001;
	localparam logic [3:0] OR = 4'b0010;
	localparam logic [3:0] XOR = 4'b0011;
	localparam logic [3:0] NOT = 4'b1111;
	localparam logic [3:0] MOV = 4'b1101;

	// shift group
	localparam logic [3:0] LSH = 4'b0100;
	localparam logic [3:0] LSHI = 4'b0000;
	localparam logic [3:0] RSH = 4'b1100;
	localparam logic [3:0] RSHI = 4'b0001;
	localparam logic [3:0] ALSH = 4'b0101;
	localparam logic [3:0] ARSH = 4'b1101;

	// memory and jump group
	localparam logic [3:0] LOAD = 4'b0000;
	localparam logic [3:0] STOR = 4'b0100;
	localparam logic [3:0] JCOND = 4'b1100;

endpackage

// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// instruction queue entries
// also the sender credit count after reset
// power of two, 2 or more
`define QUEUE_DEPTH 4

// general purpose registers
`define REG_COUNT 16

// data memory words
`define MEM_DEPTH 16

`endif
